//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 64;

	typedef logic [xlen-1:0] word_t;
	typedef logic [xlen-1:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;

	localparam addr_t reset_pc = '0;

	// major opcodes, instr[6:0]
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;

	localparam logic [2:0] funct3_beq = 3'b000;
	localparam logic [2:0] funct3_bne = 3'b001;
	localparam logic [2:0] funct3_add = 3'b000; // add, sub, addi
	localparam logic [2:0] funct3_xor = 3'b100;
	localparam logic [2:0] funct3_or = 3'b110;
	localparam logic [2:0] funct3_and = 3'b111;

	localparam logic [6:0] funct7_base = 7'b0000000;
	localparam logic [6:0] funct7_sub = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b // lui
	} alu_op_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		inst_t instr;
	} fetch_item_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		inst_t instr;
		word_t op_a;
		word_t op_b;
		word_t br_imm; // b-imm, or j-imm for jal
		alu_op_t alu_op;
		logic wen;
		reg_idx_t rd;
		logic is_branch;
		logic branch_on_equal;
		logic is_jal;
	} decoded_t;

	typedef struct packed {
		logic valid;
		addr_t target;
	} redirect_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		inst_t instr;
		logic wen;
		reg_idx_t rd;
		word_t wdata;
	} commit_t;

endpackage

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit import rv_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input redirect_t redirect,
	output logic imem_req,
	output addr_t imem_addr,
	input wire logic imem_ack,
	input inst_t imem_data,
	output fetch_item_t fetch
);

	typedef enum logic {
		fs_idle, // req low, issue once ack has fallen
		fs_wait  // req high, waiting for ack
	} fetch_state_t;

	fetch_state_t state;
	addr_t pc; // next address to request
	logic discard; // outstanding response is wrong-path

	assign imem_req = (state == fs_wait);

	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fs_idle;
			pc <= reset_pc;
			discard <= 1'b0;
			fetch.valid <= 1'b0;
		end else begin
			fetch.valid <= 1'b0;
			if (redirect.valid) begin
				pc <= redirect.target;
			end
			case (state)
				fs_idle: begin
					// hold off during redirect so the new target goes out next
					if (!imem_ack && !redirect.valid) begin
						state <= fs_wait;
					end
				end
				fs_wait: begin
					if (imem_ack) begin
						state <= fs_idle;
						discard <= 1'b0;
						fetch.valid <= !discard && !redirect.valid;
						if (!discard && !redirect.valid) begin
							pc <= pc + 64'd4;
						end
					end else if (redirect.valid) begin
						discard <= 1'b1; // finish handshake, drop data
					end
				end
				default: begin
					state <= fs_idle;
				end
			endcase
		end
	end

	// address held stable for the whole request
	always_ff @(posedge clock) begin
		if (state == fs_idle && !imem_ack && !redirect.valid) begin
			imem_addr <= pc;
		end
	end

	// response payload
	always_ff @(posedge clock) begin
		if (state == fs_wait && imem_ack) begin
			fetch.pc <= imem_addr;
			fetch.instr <= imem_data;
		end
	end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`default_nettype none

module reg_file import rv_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input reg_idx_t rs1,
	input reg_idx_t rs2,
	output word_t rs1_data,
	output word_t rs2_data,
	input wire logic wen,
	input reg_idx_t rd,
	input word_t wdata
);

	word_t regs [32];

	function automatic word_t read_port(input reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end else if (wen && rd == idx) begin
			return wdata; // write-through
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`default_nettype none

module decode_stage import rv_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input fetch_item_t fetch,
	input redirect_t redirect,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	input word_t rs1_data,
	input word_t rs2_data,
	output decoded_t decoded
);

	fetch_item_t q;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t rd;
	word_t imm_i;
	word_t imm_u;
	word_t imm_b;
	word_t imm_j;

	always_ff @(posedge clock) begin
		q <= fetch;
		if (reset || redirect.valid) begin
			q.valid <= 1'b0; // wrong-path item dropped
		end
	end

	assign opcode = q.instr[6:0];
	assign rd = q.instr[11:7];
	assign funct3 = q.instr[14:12];
	assign rs1 = q.instr[19:15];
	assign rs2 = q.instr[24:20];
	assign funct7 = q.instr[31:25];

	assign imm_i = {{52{q.instr[31]}}, q.instr[31:20]};
	assign imm_u = {{32{q.instr[31]}}, q.instr[31:12], 12'b0};
	assign imm_b = {{51{q.instr[31]}}, q.instr[31], q.instr[7], q.instr[30:25],
		q.instr[11:8], 1'b0};
	assign imm_j = {{43{q.instr[31]}}, q.instr[31], q.instr[19:12], q.instr[20],
		q.instr[30:21], 1'b0};

	always_comb begin
		decoded.valid = q.valid && !redirect.valid;
		decoded.pc = q.pc;
		decoded.instr = q.instr;
		decoded.op_a = rs1_data;
		decoded.op_b = rs2_data;
		decoded.br_imm = imm_b;
		decoded.alu_op = alu_add;
		decoded.wen = 1'b0;
		decoded.rd = rd;
		decoded.is_branch = 1'b0;
		decoded.branch_on_equal = 1'b0;
		decoded.is_jal = 1'b0;

		case (opcode)
			op_imm: begin
				decoded.op_b = imm_i;
				decoded.wen = (funct3 == funct3_add); // addi only
			end
			op_reg: begin
				decoded.wen = (funct7 == funct7_base) ||
					(funct7 == funct7_sub && funct3 == funct3_add);
				case (funct3)
					funct3_add: decoded.alu_op = (funct7 == funct7_sub) ? alu_sub : alu_add;
					funct3_xor: decoded.alu_op = alu_xor;
					funct3_or: decoded.alu_op = alu_or;
					funct3_and: decoded.alu_op = alu_and;
					default: decoded.wen = 1'b0; // shifts, compares
				endcase
			end
			op_lui: begin
				decoded.op_b = imm_u;
				decoded.alu_op = alu_pass_b;
				decoded.wen = 1'b1;
			end
			op_branch: begin
				decoded.is_branch = (funct3 == funct3_beq) || (funct3 == funct3_bne);
				decoded.branch_on_equal = (funct3 == funct3_beq);
			end
			op_jal: begin
				decoded.op_a = q.pc; // link = pc + 4 through the adder
				decoded.op_b = 64'd4;
				decoded.br_imm = imm_j;
				decoded.wen = 1'b1;
				decoded.is_jal = 1'b1;
			end
			default: begin
				decoded.wen = 1'b0;
			end
		endcase

		if (rd == '0) begin
			decoded.wen = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`default_nettype none

module execute_stage import rv_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input decoded_t decoded,
	output logic wen,
	output reg_idx_t rd,
	output word_t wdata,
	output redirect_t redirect,
	output commit_t commit
);

	decoded_t q;
	word_t result;
	logic equal;
	logic taken;

	always_ff @(posedge clock) begin
		q <= decoded;
		if (reset) begin
			q.valid <= 1'b0;
		end
	end

	always_comb begin
		case (q.alu_op)
			alu_add: result = q.op_a + q.op_b;
			alu_sub: result = q.op_a - q.op_b;
			alu_and: result = q.op_a & q.op_b;
			alu_or: result = q.op_a | q.op_b;
			alu_xor: result = q.op_a ^ q.op_b;
			alu_pass_b: result = q.op_b;
			default: result = q.op_a + q.op_b;
		endcase
	end

	// branches carry rs1 and rs2 in op_a and op_b
	assign equal = (q.op_a == q.op_b);
	assign taken = q.is_branch && (equal == q.branch_on_equal);

	assign redirect.valid = q.valid && (taken || q.is_jal);
	assign redirect.target = q.pc + q.br_imm;

	// register file updates on the edge ending execute
	assign wen = q.valid && q.wen;
	assign rd = q.rd;
	assign wdata = result;

	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= q.valid;
		end
	end

	always_ff @(posedge clock) begin
		commit.pc <= q.pc;
		commit.instr <= q.instr;
		commit.wen <= q.wen;
		commit.rd <= q.rd;
		commit.wdata <= result;
	end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	output logic imem_req,
	output addr_t imem_addr,
	input wire logic imem_ack,
	input inst_t imem_data,
	output commit_t commit
);

	fetch_item_t fetch;
	decoded_t decoded;
	redirect_t redirect;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t rs1_data;
	word_t rs2_data;
	logic wen;
	reg_idx_t rd;
	word_t wdata;

	fetch_unit u_fetch (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_data(imem_data),
		.fetch(fetch)
	);

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.redirect(redirect),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.decoded(decoded)
	);

	reg_file u_regs (
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wen(wen),
		.rd(rd),
		.wdata(wdata)
	);

	execute_stage u_execute (
		.clock(clock),
		.reset(reset),
		.decoded(decoded),
		.wen(wen),
		.rd(rd),
		.wdata(wdata),
		.redirect(redirect),
		.commit(commit)
	);

endmodule

`default_nettype wire

//--- test/core_chk.sv
`default_nettype none

module core_chk import rv_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic imem_req,
	input addr_t imem_addr,
	input wire logic imem_ack,
	input commit_t commit
);

	int failures = 0;

	// phase 1 starts only after memory released ack
	req_waits_for_ack_low: assert property (@(posedge clock) disable iff (reset)
		$rose(imem_req) |-> !$past(imem_ack))
		else begin
			$error("imem_req rose while imem_ack was high");
			failures++;
		end

	addr_stable_during_req: assert property (@(posedge clock) disable iff (reset)
		imem_req && $past(imem_req) |-> $stable(imem_addr))
		else begin
			$error("imem_addr changed while imem_req was high");
			failures++;
		end

	no_write_to_x0: assert property (@(posedge clock) disable iff (reset)
		commit.valid && commit.wen |-> commit.rd != '0)
		else begin
			$error("commit with wen high and rd zero");
			failures++;
		end

endmodule

`default_nettype wire

//--- test/core_tb.sv
`default_nettype none

module core_tb import rv_pkg::*; ();

	localparam int max_words = 16;
	localparam int max_ack_delay = 4;
	localparam int reset_cycles = 16;
	localparam int drive_delay = 1;
	localparam int run_budget = max_words * (max_ack_delay + 4) * 4; // cycles per run
	localparam int watchdog_cycles = 8 * (reset_cycles + run_budget); // seven runs + margin

	logic clock;
	logic reset;
	logic imem_req;
	addr_t imem_addr;
	logic imem_ack;
	inst_t imem_data;
	commit_t commit;

	inst_t mem [max_words];
	int mem_len;
	int ack_delay_limit;
	integer seed;
	commit_t expected [$];
	commit_t observed [$];
	int tests_run;
	int tests_failed;
	int checks_failed;

	rv_core uut (
		.clock(clock),
		.reset(reset),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_data(imem_data),
		.commit(commit)
	);

	bind rv_core core_chk chk (
		.clock(clock),
		.reset(reset),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.commit(commit)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	function automatic inst_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
	endfunction

	function automatic inst_t i_type(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic inst_t u_type(int imm, int rd);
		return {imm[19:0], rd[4:0], op_lui};
	endfunction

	function automatic inst_t b_type(int off, int rs1, int rs2, logic [2:0] f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic inst_t j_type(int off, int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
	endfunction

	function automatic inst_t read_word(addr_t addr);
		logic [31:0] folded;
		if (addr[1:0] == 2'b00 && addr[63:2] < 62'(mem_len)) return mem[addr[5:2]];
		folded = addr[31:0] ^ addr[63:32]; // outside the program
		return {folded[31:7] ^ {18'b0, folded[6:0]}, 7'b1111111};
	endfunction

	function automatic int pick_delay();
		int r;
		if (ack_delay_limit == 0) return 0;
		r = $random(seed) & 32'h7fff_ffff;
		return r % (ack_delay_limit + 1);
	endfunction

	// memory side of the four-phase handshake
	initial begin
		int wait_left;
		bit counting;
		imem_ack = 1'b0;
		imem_data = '0;
		wait_left = 0;
		counting = 1'b0;
		forever begin
			@(posedge clock);
			#drive_delay;
			if (imem_ack) begin
				if (!imem_req) imem_ack = 1'b0;
			end else if (!imem_req) begin
				counting = 1'b0;
			end else begin
				if (!counting) begin
					counting = 1'b1;
					wait_left = pick_delay();
				end
				if (wait_left == 0) begin
					imem_data = read_word(imem_addr);
					imem_ack = 1'b1;
					counting = 1'b0;
				end else begin
					wait_left--;
				end
			end
		end
	end

	function automatic void emit(inst_t w);
		mem[mem_len] = w;
		mem_len++;
	endfunction

	function automatic void load_program(int id);
		mem_len = 0;
		case (id)
			0: begin // dependent alu chain
				emit(i_type(100, 0, funct3_add, 1, op_imm));
				emit(i_type(-3, 1, funct3_add, 2, op_imm));
				emit(r_type(funct7_base, 2, 1, funct3_add, 3));
				emit(r_type(funct7_sub, 1, 3, funct3_add, 4));
				emit(r_type(funct7_base, 3, 4, funct3_and, 5));
				emit(r_type(funct7_base, 2, 5, funct3_or, 6));
				emit(r_type(funct7_base, 1, 6, funct3_xor, 7));
				emit(r_type(funct7_sub, 7, 0, funct3_add, 8));
				emit(i_type(-2048, 8, funct3_add, 9, op_imm));
			end
			1: begin // lui and x0 writes
				emit(u_type(32'h12345, 1));
				emit(u_type(32'h80000, 2));
				emit(i_type(32'h678, 1, funct3_add, 1, op_imm));
				emit(i_type(1, 1, funct3_add, 0, op_imm));
				emit(r_type(funct7_base, 2, 1, funct3_add, 0));
				emit(u_type(1, 0));
				emit(r_type(funct7_base, 1, 0, funct3_add, 3));
				emit(r_type(funct7_base, 0, 2, funct3_or, 5));
			end
			2: begin // branches and jal
				emit(i_type(3, 0, funct3_add, 1, op_imm));
				emit(i_type(3, 0, funct3_add, 2, op_imm));
				emit(b_type(8, 1, 2, funct3_beq)); // taken
				emit(i_type(99, 0, funct3_add, 3, op_imm));
				emit(b_type(8, 1, 2, funct3_bne)); // not taken
				emit(i_type(1, 0, funct3_add, 4, op_imm));
				emit(i_type(1, 2, funct3_add, 2, op_imm));
				emit(b_type(12, 1, 2, funct3_bne)); // taken, skips two
				emit(i_type(55, 0, funct3_add, 5, op_imm));
				emit(i_type(66, 0, funct3_add, 6, op_imm));
				emit(b_type(8, 1, 2, funct3_beq)); // not taken
				emit(j_type(8, 7));
				emit(i_type(77, 0, funct3_add, 8, op_imm));
				emit(r_type(funct7_base, 4, 7, funct3_add, 9));
			end
			default: begin // unsupported opcodes in between
				emit(i_type(10, 0, funct3_add, 1, op_imm));
				emit(i_type(7, 1, 3'b000, 1, 7'b0001011));
				emit(i_type(1, 1, funct3_add, 2, op_imm));
				emit(i_type(0, 1, 3'b011, 3, 7'b0000011)); // ld
				emit(i_type(4, 3, funct3_add, 4, op_imm));
				emit(32'hffff_ffff);
				emit(r_type(funct7_base, 4, 2, funct3_add, 5));
			end
		endcase
		emit(j_type(0, 0)); // self-loop ends every program
	endfunction

	// ISA-level model, one record per retired instruction
	function automatic void build_expected();
		word_t regs [32];
		addr_t pc;
		addr_t next_pc;
		inst_t ins;
		word_t a;
		word_t b;
		word_t value;
		logic writes;
		commit_t rec;
		regs = '{default: '0};
		pc = reset_pc;
		expected.delete();
		for (int step = 0; step < 4 * max_words; step++) begin
			ins = read_word(pc);
			a = regs[ins[19:15]];
			b = regs[ins[24:20]];
			value = pc + 64'd4;
			writes = 1'b0;
			next_pc = pc + 64'd4;
			case (ins[6:0])
				op_imm: begin
					value = a + {{52{ins[31]}}, ins[31:20]};
					writes = (ins[14:12] == 3'b000);
				end
				op_reg: begin
					writes = 1'b1;
					if (ins[31:25] == 7'b0100000 && ins[14:12] == 3'b000) value = a - b;
					else if (ins[31:25] != 7'b0) writes = 1'b0;
					else if (ins[14:12] == 3'b000) value = a + b;
					else if (ins[14:12] == 3'b100) value = a ^ b;
					else if (ins[14:12] == 3'b110) value = a | b;
					else if (ins[14:12] == 3'b111) value = a & b;
					else writes = 1'b0;
				end
				op_lui: begin
					value = {{32{ins[31]}}, ins[31:12], 12'b0};
					writes = 1'b1;
				end
				op_branch: begin
					if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b))
						next_pc = pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
				op_jal: begin
					writes = 1'b1;
					next_pc = pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				default: writes = 1'b0;
			endcase
			rec = '{valid: 1'b1, pc: pc, instr: ins, wen: writes && ins[11:7] != 5'd0,
				rd: ins[11:7], wdata: value};
			expected.push_back(rec);
			if (rec.wen) regs[rec.rd] = value;
			if (next_pc == pc) break;
			pc = next_pc;
		end
	endfunction

	function automatic bit same_commit(commit_t got, commit_t want);
		if (got.pc != want.pc || got.instr != want.instr || got.wen != want.wen) return 1'b0;
		if (want.wen && (got.rd != want.rd || got.wdata != want.wdata)) return 1'b0;
		return 1'b1;
	endfunction

	task automatic run_program(input int id, input int delay_limit, output int errors);
		int got;
		int cycles;
		bit req_seen;
		errors = 0;
		reset = 1'b1;
		load_program(id);
		ack_delay_limit = delay_limit;
		build_expected();
		observed.delete();
		repeat (reset_cycles) begin
			@(posedge clock);
			#drive_delay;
			if (imem_req || commit.valid) begin
				$display("request or commit seen during reset at time %0t", $time);
				errors++;
			end
		end
		reset = 1'b0;
		got = 0;
		cycles = 0;
		req_seen = 1'b0;
		while (got < expected.size() && cycles < run_budget) begin
			@(posedge clock);
			#drive_delay;
			cycles++;
			if (imem_req && !req_seen) begin
				req_seen = 1'b1;
				if (imem_addr != 64'd0) begin
					$display("mismatch at time %0t: first request at %h, expected 0",
						$time, imem_addr);
					errors++;
				end
			end
			if (commit.valid) begin
				observed.push_back(commit);
				if (!same_commit(commit, expected[got])) begin
					$write("mismatch at time %0t: commit %0d pc %h instr %h wen %0b rd %0d wdata %h",
						$time, got, commit.pc, commit.instr, commit.wen, commit.rd, commit.wdata);
					$display(", expected pc %h instr %h wen %0b rd %0d wdata %h", expected[got].pc,
						expected[got].instr, expected[got].wen, expected[got].rd, expected[got].wdata);
					errors++;
				end
				got++;
			end
		end
		if (got < expected.size()) begin
			$display("commit stream stalled: %0d of %0d records arrived", got, expected.size());
			errors++;
		end
	endtask

	task automatic finish_test(string name, int errors);
		tests_run++;
		if (errors != 0) tests_failed++;
		checks_failed += errors;
		$display("test %s: %0d errors", name, errors);
	endtask

	task automatic program_test(string name, int id, int delay_limit);
		int errors;
		run_program(id, delay_limit, errors);
		finish_test(name, errors);
	endtask

	task automatic delay_compare_test();
		int errors;
		int more;
		commit_t first_run [$];
		run_program(2, 0, errors);
		first_run = observed;
		run_program(2, max_ack_delay, more);
		errors += more;
		if (first_run.size() != observed.size()) begin
			$display("commit counts differ: %0d with zero delay, %0d with random delay",
				first_run.size(), observed.size());
			errors++;
		end else begin
			foreach (first_run[i]) begin
				if (first_run[i] != observed[i]) begin
					$display("mismatch at time %0t: commit %0d differs between delay settings",
						$time, i);
					errors++;
				end
			end
		end
		finish_test("zero versus random ack delay", errors);
	endtask

	initial begin
		int limit;
		limit = watchdog_cycles;
		repeat (limit) @(posedge clock);
		$display("watchdog expired after %0d cycles", limit);
		$display("Test failures found");
		$finish;
	end

	initial begin
		seed = 39944;
		reset = 1'b1;
		mem_len = 0;
		ack_delay_limit = 0;
		tests_run = 0;
		tests_failed = 0;
		checks_failed = 0;
		program_test("reset and first fetch", 0, 0);
		program_test("dependent alu chain", 0, max_ack_delay);
		program_test("lui and x0 writes", 1, max_ack_delay);
		program_test("branches and jal", 2, max_ack_delay);
		program_test("unsupported opcodes", 3, max_ack_delay);
		delay_compare_test();
		$display("tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
			tests_run, tests_failed, checks_failed, uut.chk.failures);
		if (tests_failed == 0 && uut.chk.failures == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/rv_core.sv
test/core_chk.sv
test/core_tb.sv

//--- run.sh
#!/bin/sh
# build the core testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module core_tb -o core_sim \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/core_sim)
echo "$out"
echo "$out" | grep -qx 'All tests passed!' && echo "PASS" || { echo "FAIL"; exit 1; }
